// ==== source/pipe_defines.svh ====
// build-time sizes only; PIPE_DMEM_DEPTH must stay a power of two for the word index
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// ==================================================
// datapath
// ==================================================

// data and address width
`define PIPE_DATA_W 32

// register address width, gives 32 registers
`define PIPE_REG_ADDR_W 5

// ==================================================
// data memory
// ==================================================

// depth in 32-bit words, indexed by address bits above the byte offset
`define PIPE_DMEM_DEPTH 64

`endif

// ==== source/pipe_pkg.sv ====
// encodings are shared with the decoder; ALU codes 10 to 15 are reserved and trap
package pipe_pkg;

	// ==================================================
	// execute controls
	// ==================================================

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLT  = 4'd5,
		ALU_SLL  = 4'd6,
		ALU_SRL  = 4'd7,
		ALU_LUI  = 4'd8,
		ALU_MULT = 4'd9
	} alu_op_t;

	// second ALU operand
	typedef enum logic {
		SRC_REG = 1'b0,
		SRC_IMM = 1'b1
	} alu_src_t;

	// condition tested on the ALU result
	typedef enum logic [1:0] {
		BR_NONE   = 2'd0,
		BR_EQZ    = 2'd1,
		BR_NEZ    = 2'd2,
		BR_UNCOND = 2'd3
	} branch_op_t;

	// ==================================================
	// memory and exceptions
	// ==================================================

	// word access only, code 3 unused
	typedef enum logic [1:0] {
		MEM_NONE = 2'd0,
		MEM_LW   = 2'd1,
		MEM_SW   = 2'd2
	} mem_op_t;

	typedef enum logic [2:0] {
		EXC_NONE    = 3'd0,
		EXC_SYSCALL = 3'd1,
		EXC_RI      = 3'd2,
		EXC_ADEL    = 3'd3,
		EXC_ADES    = 3'd4
	} exc_code_t;

endpackage

// ==== source/reg_file.sv ====
// register 0 reads zero; a write in the same cycle is bypassed to both read ports
`timescale 1ns/1ps
`include "pipe_defines.svh"

module reg_file (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [`PIPE_REG_ADDR_W-1:0] rs_addr,
	input  logic [`PIPE_REG_ADDR_W-1:0] rt_addr,
	output logic [`PIPE_DATA_W-1:0]     rs_data,
	output logic [`PIPE_DATA_W-1:0]     rt_data,
	input  logic                        wr_en,
	input  logic [`PIPE_REG_ADDR_W-1:0] wr_addr,
	input  logic [`PIPE_DATA_W-1:0]     wr_data
);

	localparam int NUM_REGS = 1 << `PIPE_REG_ADDR_W;

	logic [`PIPE_DATA_W-1:0] regs [NUM_REGS];

	// zero register first, then bypass, then storage
	function automatic logic [`PIPE_DATA_W-1:0] read_port(
		input logic [`PIPE_REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wr_en && wr_addr == addr)
			return wr_data;
		else
			return regs[addr];
	endfunction

	assign rs_data = read_port(rs_addr);
	assign rt_data = read_port(rt_addr);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// a write aimed at register 0 leaves it zero
	a_reg0_zero: assert property (@(posedge clk) disable iff (!arst_n)
		wr_en && wr_addr == '0 |=> regs[0] == '0);

endmodule

// ==== source/stage_issue.sv ====
// ID/EX register; operands sampled with the decoded fields, no forwarding or hazard check
`timescale 1ns/1ps
`include "pipe_defines.svh"

module stage_issue (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        stall,
	input  logic                        clear,

	// decoded instruction
	input  pipe_pkg::alu_op_t           alu_op,
	input  pipe_pkg::alu_src_t          alu_src,
	input  logic [`PIPE_DATA_W-1:0]     imm,
	input  logic [`PIPE_REG_ADDR_W-1:0] dec_rs_addr,
	input  logic [`PIPE_REG_ADDR_W-1:0] dec_rt_addr,
	input  logic [`PIPE_REG_ADDR_W-1:0] dec_wb_addr,
	input  pipe_pkg::branch_op_t        branch_op,
	input  logic [`PIPE_DATA_W-1:0]     branch_target,
	input  logic                        branch_target_reg,
	input  pipe_pkg::mem_op_t           mem_op,
	input  pipe_pkg::exc_code_t         exc_code_in,
	input  logic [`PIPE_DATA_W-1:0]     pc,

	// register file read side
	output logic [`PIPE_REG_ADDR_W-1:0] rs_addr,
	output logic [`PIPE_REG_ADDR_W-1:0] rt_addr,
	input  logic [`PIPE_DATA_W-1:0]     rs_data,
	input  logic [`PIPE_DATA_W-1:0]     rt_data,

	// ID/EX
	output pipe_pkg::alu_op_t           id_alu_op,
	output pipe_pkg::alu_src_t          id_alu_src,
	output logic [`PIPE_DATA_W-1:0]     id_imm,
	output logic [`PIPE_DATA_W-1:0]     id_reg1,
	output logic [`PIPE_DATA_W-1:0]     id_reg2,
	output logic [`PIPE_REG_ADDR_W-1:0] id_wb_addr,
	output pipe_pkg::branch_op_t        id_branch_op,
	output logic [`PIPE_DATA_W-1:0]     id_branch_target,
	output logic                        id_branch_target_reg,
	output pipe_pkg::mem_op_t           id_mem_op,
	output pipe_pkg::exc_code_t         id_exc_code,
	output logic [`PIPE_DATA_W-1:0]     id_pc
);

	assign rs_addr = dec_rs_addr;
	assign rt_addr = dec_rt_addr;

	// control fields; a bubble is an add that writes nowhere
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n || clear) begin
			id_alu_op    <= pipe_pkg::ALU_ADD;
			id_wb_addr   <= '0;
			id_branch_op <= pipe_pkg::BR_NONE;
			id_mem_op    <= pipe_pkg::MEM_NONE;
			id_exc_code  <= pipe_pkg::EXC_NONE;
		end else if (!stall) begin
			id_alu_op    <= alu_op;
			// decode fault never reaches the register file
			id_wb_addr   <= (exc_code_in != pipe_pkg::EXC_NONE) ? '0 : dec_wb_addr;
			id_branch_op <= branch_op;
			id_mem_op    <= mem_op;
			id_exc_code  <= exc_code_in;
		end
	end

	// operands and payload
	always_ff @(posedge clk) begin
		if (!stall) begin
			id_alu_src           <= alu_src;
			id_imm               <= imm;
			id_reg1              <= rs_data;
			id_reg2              <= rt_data;
			id_branch_target     <= branch_target;
			id_branch_target_reg <= branch_target_reg;
			id_pc                <= pc;
		end
	end

endmodule

// ==== source/alu.sv ====
// combinational; shifts apply to opr1 by sa_imm[4:0], mult yields zero here
`timescale 1ns/1ps
`include "pipe_defines.svh"

module alu (
	input  logic [`PIPE_DATA_W-1:0] opr1,
	input  logic [`PIPE_DATA_W-1:0] opr2,
	input  logic [`PIPE_DATA_W-1:0] sa_imm,
	input  pipe_pkg::alu_op_t       op,
	output logic [`PIPE_DATA_W-1:0] result,
	output logic                    illegal_op
);

	localparam int SHAMT_W = $clog2(`PIPE_DATA_W);

	logic [SHAMT_W-1:0] shamt;

	assign shamt = sa_imm[SHAMT_W-1:0];

	always_comb begin
		illegal_op = 1'b0;
		case (op)
			pipe_pkg::ALU_ADD:  result = opr1 + opr2;
			pipe_pkg::ALU_SUB:  result = opr1 - opr2;
			pipe_pkg::ALU_AND:  result = opr1 & opr2;
			pipe_pkg::ALU_OR:   result = opr1 | opr2;
			pipe_pkg::ALU_XOR:  result = opr1 ^ opr2;
			// signed compare, one in the lsb
			pipe_pkg::ALU_SLT: begin
				result = '0;
				result[0] = $signed(opr1) < $signed(opr2);
			end
			pipe_pkg::ALU_SLL:  result = opr1 << shamt;
			pipe_pkg::ALU_SRL:  result = opr1 >> shamt;
			pipe_pkg::ALU_LUI:  result = sa_imm << 16;
			// product is formed outside
			pipe_pkg::ALU_MULT: result = '0;
			default: begin
				result     = '0;
				illegal_op = 1'b1;
			end
		endcase
	end

endmodule

// ==== source/stage_ex.sv ====
// branch outputs move on the falling edge even under stall; no forwarding into the ALU
`timescale 1ns/1ps
`include "pipe_defines.svh"

module stage_ex (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        stall,
	input  logic                        clear,

	// ID/EX
	input  pipe_pkg::alu_op_t           id_alu_op,
	input  pipe_pkg::alu_src_t          id_alu_src,
	input  logic [`PIPE_DATA_W-1:0]     id_imm,
	input  logic [`PIPE_DATA_W-1:0]     id_reg1,
	input  logic [`PIPE_DATA_W-1:0]     id_reg2,
	input  logic [`PIPE_REG_ADDR_W-1:0] id_wb_addr,
	input  pipe_pkg::branch_op_t        id_branch_op,
	input  logic [`PIPE_DATA_W-1:0]     id_branch_target,
	input  logic                        id_branch_target_reg,
	input  pipe_pkg::mem_op_t           id_mem_op,
	input  pipe_pkg::exc_code_t         id_exc_code,
	input  logic [`PIPE_DATA_W-1:0]     id_pc,

	output logic                        branch_flag,
	output logic [`PIPE_DATA_W-1:0]     branch_dest,
	output logic [`PIPE_DATA_W-1:0]     mult_opr1,
	output logic [`PIPE_DATA_W-1:0]     mult_opr2,

	// EX/MEM
	output logic [`PIPE_DATA_W-1:0]     ex_alu_result,
	output logic [`PIPE_REG_ADDR_W-1:0] ex_wb_addr,
	output pipe_pkg::mem_op_t           ex_mem_op,
	output logic [`PIPE_DATA_W-1:0]     ex_mem_data,
	output pipe_pkg::exc_code_t         ex_exc_code,
	output logic [`PIPE_DATA_W-1:0]     ex_pc
);

	logic [`PIPE_DATA_W-1:0] alu_opr2;
	logic [`PIPE_DATA_W-1:0] alu_result;
	logic                    alu_illegal;
	logic                    branch_taken;
	logic                    ex_branch_taken;
	logic [`PIPE_DATA_W-1:0] ex_branch_dest;
	pipe_pkg::exc_code_t     exc_next;
	logic                    fault;

	assign alu_opr2 = (id_alu_src == pipe_pkg::SRC_IMM) ? id_imm : id_reg2;

	alu u_alu (
		.opr1       (id_reg1),
		.opr2       (alu_opr2),
		.sa_imm     (id_imm),
		.op         (id_alu_op),
		.result     (alu_result),
		.illegal_op (alu_illegal)
	);

	// ==================================================
	// branch resolution
	// ==================================================

	always_comb begin
		case (id_branch_op)
			pipe_pkg::BR_EQZ:    branch_taken = (alu_result == '0);
			pipe_pkg::BR_NEZ:    branch_taken = (alu_result != '0);
			pipe_pkg::BR_UNCOND: branch_taken = 1'b1;
			default:             branch_taken = 1'b0;
		endcase
	end

	// resolved branch travels with the instruction into EX/MEM
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n || clear)
			ex_branch_taken <= 1'b0;
		else if (!stall)
			ex_branch_taken <= branch_taken;
	end

	// register-indirect target comes from rt
	always_ff @(posedge clk) begin
		if (!stall)
			ex_branch_dest <= id_branch_target_reg ? id_reg2 : id_branch_target;
	end

	// half a cycle later it reaches the outputs
	always_ff @(negedge clk or negedge arst_n) begin
		if (!arst_n)
			branch_flag <= 1'b0;
		else
			branch_flag <= ex_branch_taken;
	end

	always_ff @(negedge clk) begin
		branch_dest <= ex_branch_dest;
	end

	// ==================================================
	// exception priority and EX/MEM
	// ==================================================

	// decode exception wins over reserved instruction
	always_comb begin
		if (id_exc_code != pipe_pkg::EXC_NONE)
			exc_next = id_exc_code;
		else if (alu_illegal)
			exc_next = pipe_pkg::EXC_RI;
		else
			exc_next = pipe_pkg::EXC_NONE;
	end

	assign fault = (exc_next != pipe_pkg::EXC_NONE);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n || clear) begin
			ex_wb_addr  <= '0;
			ex_mem_op   <= pipe_pkg::MEM_NONE;
			ex_exc_code <= pipe_pkg::EXC_NONE;
		end else if (!stall) begin
			ex_wb_addr  <= fault ? '0 : id_wb_addr;
			ex_mem_op   <= fault ? pipe_pkg::MEM_NONE : id_mem_op;
			ex_exc_code <= exc_next;
		end
	end

	// alu result is also the memory address
	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_alu_result <= alu_result;
			ex_mem_data   <= id_reg2;
			ex_pc         <= id_pc;
		end
		if (!stall && !clear && !fault && id_alu_op == pipe_pkg::ALU_MULT) begin
			mult_opr1 <= id_reg1;
			mult_opr2 <= id_reg2;
		end
	end

	// a faulting instruction never touches memory downstream
	a_exc_no_mem: assert property (@(posedge clk) disable iff (!arst_n)
		ex_exc_code != pipe_pkg::EXC_NONE |-> ex_mem_op == pipe_pkg::MEM_NONE);

endmodule

// ==== source/stage_mem_wb.sv ====
// word access only, index from address bits above the offset wraps modulo the depth
`timescale 1ns/1ps
`include "pipe_defines.svh"

module stage_mem_wb (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        stall,
	input  logic                        clear,

	// EX/MEM
	input  logic [`PIPE_DATA_W-1:0]     ex_alu_result,
	input  logic [`PIPE_REG_ADDR_W-1:0] ex_wb_addr,
	input  pipe_pkg::mem_op_t           ex_mem_op,
	input  logic [`PIPE_DATA_W-1:0]     ex_mem_data,
	input  pipe_pkg::exc_code_t         ex_exc_code,
	input  logic [`PIPE_DATA_W-1:0]     ex_pc,

	output logic                        wb_en,
	output logic [`PIPE_REG_ADDR_W-1:0] wb_addr,
	output logic [`PIPE_DATA_W-1:0]     wb_data,
	output logic                        exc_valid,
	output pipe_pkg::exc_code_t         exc_code,
	output logic [`PIPE_DATA_W-1:0]     exc_epc,
	output logic [`PIPE_DATA_W-1:0]     exc_badvaddr
);

	localparam int IDX_W = $clog2(`PIPE_DMEM_DEPTH);

	logic [`PIPE_DATA_W-1:0] dmem [`PIPE_DMEM_DEPTH];
	logic [IDX_W-1:0]        mem_idx;
	logic                    advance;
	logic                    misalign;
	logic                    is_load;
	logic                    is_store;
	logic                    wb_ok;
	pipe_pkg::exc_code_t     exc_next;

	// stall or clear keep this stage from retiring anything
	assign advance  = !stall && !clear;
	assign mem_idx  = ex_alu_result[IDX_W+1:2];
	assign misalign = (ex_alu_result[1:0] != 2'b00);
	assign is_load  = (ex_mem_op == pipe_pkg::MEM_LW);
	assign is_store = (ex_mem_op == pipe_pkg::MEM_SW);

	always_comb begin
		if (ex_exc_code != pipe_pkg::EXC_NONE)
			exc_next = ex_exc_code;
		else if (is_load && misalign)
			exc_next = pipe_pkg::EXC_ADEL;
		else if (is_store && misalign)
			exc_next = pipe_pkg::EXC_ADES;
		else
			exc_next = pipe_pkg::EXC_NONE;
	end

	assign wb_ok = (ex_wb_addr != '0) && (exc_next == pipe_pkg::EXC_NONE) && !is_store;

	always_ff @(posedge clk) begin
		if (advance && is_store && !misalign)
			dmem[mem_idx] <= ex_mem_data;
	end

	// one-cycle strobes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_en     <= 1'b0;
			exc_valid <= 1'b0;
			exc_code  <= pipe_pkg::EXC_NONE;
		end else begin
			wb_en     <= advance && wb_ok;
			exc_valid <= advance && (exc_next != pipe_pkg::EXC_NONE);
			if (advance)
				exc_code <= exc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			wb_addr      <= ex_wb_addr;
			wb_data      <= is_load ? dmem[mem_idx] : ex_alu_result;
			exc_epc      <= ex_pc;
			exc_badvaddr <= ex_alu_result;
		end
	end

	a_wb_xor_exc: assert property (@(posedge clk) disable iff (!arst_n)
		!(wb_en && exc_valid));

endmodule

// ==== source/ex_pipe_top.sv ====
// decoded fields in, results after two edges; software keeps dependent ops two slots apart
`timescale 1ns/1ps
`include "pipe_defines.svh"

module ex_pipe_top (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        stall,
	input  logic                        clear,

	// decoded instruction
	input  pipe_pkg::alu_op_t           alu_op,
	input  pipe_pkg::alu_src_t          alu_src,
	input  logic [`PIPE_DATA_W-1:0]     imm,
	input  logic [`PIPE_REG_ADDR_W-1:0] rs_addr,
	input  logic [`PIPE_REG_ADDR_W-1:0] rt_addr,
	input  logic [`PIPE_REG_ADDR_W-1:0] dec_wb_addr,
	input  pipe_pkg::branch_op_t        branch_op,
	input  logic [`PIPE_DATA_W-1:0]     branch_target,
	input  logic                        branch_target_reg,
	input  pipe_pkg::mem_op_t           mem_op,
	input  pipe_pkg::exc_code_t         exc_code_in,
	input  logic [`PIPE_DATA_W-1:0]     pc,

	output logic                        branch_flag,
	output logic [`PIPE_DATA_W-1:0]     branch_dest,
	output logic [`PIPE_DATA_W-1:0]     mult_opr1,
	output logic [`PIPE_DATA_W-1:0]     mult_opr2,
	output logic                        wb_en,
	output logic [`PIPE_REG_ADDR_W-1:0] wb_addr,
	output logic [`PIPE_DATA_W-1:0]     wb_data,
	output logic                        exc_valid,
	output pipe_pkg::exc_code_t         exc_code,
	output logic [`PIPE_DATA_W-1:0]     exc_epc,
	output logic [`PIPE_DATA_W-1:0]     exc_badvaddr
);

	logic [`PIPE_REG_ADDR_W-1:0] rf_rs_addr;
	logic [`PIPE_REG_ADDR_W-1:0] rf_rt_addr;
	logic [`PIPE_DATA_W-1:0]     rf_rs_data;
	logic [`PIPE_DATA_W-1:0]     rf_rt_data;

	// ID/EX
	pipe_pkg::alu_op_t           id_alu_op;
	pipe_pkg::alu_src_t          id_alu_src;
	logic [`PIPE_DATA_W-1:0]     id_imm;
	logic [`PIPE_DATA_W-1:0]     id_reg1;
	logic [`PIPE_DATA_W-1:0]     id_reg2;
	logic [`PIPE_REG_ADDR_W-1:0] id_wb_addr;
	pipe_pkg::branch_op_t        id_branch_op;
	logic [`PIPE_DATA_W-1:0]     id_branch_target;
	logic                        id_branch_target_reg;
	pipe_pkg::mem_op_t           id_mem_op;
	pipe_pkg::exc_code_t         id_exc_code;
	logic [`PIPE_DATA_W-1:0]     id_pc;

	// EX/MEM
	logic [`PIPE_DATA_W-1:0]     ex_alu_result;
	logic [`PIPE_REG_ADDR_W-1:0] ex_wb_addr;
	pipe_pkg::mem_op_t           ex_mem_op;
	logic [`PIPE_DATA_W-1:0]     ex_mem_data;
	pipe_pkg::exc_code_t         ex_exc_code;
	logic [`PIPE_DATA_W-1:0]     ex_pc;

	// write-back outputs close the loop to the write port
	reg_file u_reg_file (
		.clk     (clk),
		.arst_n  (arst_n),
		.rs_addr (rf_rs_addr),
		.rt_addr (rf_rt_addr),
		.rs_data (rf_rs_data),
		.rt_data (rf_rt_data),
		.wr_en   (wb_en),
		.wr_addr (wb_addr),
		.wr_data (wb_data)
	);

	stage_issue u_issue (
		.clk                  (clk),
		.arst_n               (arst_n),
		.stall                (stall),
		.clear                (clear),
		.alu_op               (alu_op),
		.alu_src              (alu_src),
		.imm                  (imm),
		.dec_rs_addr          (rs_addr),
		.dec_rt_addr          (rt_addr),
		.dec_wb_addr          (dec_wb_addr),
		.branch_op            (branch_op),
		.branch_target        (branch_target),
		.branch_target_reg    (branch_target_reg),
		.mem_op               (mem_op),
		.exc_code_in          (exc_code_in),
		.pc                   (pc),
		.rs_addr              (rf_rs_addr),
		.rt_addr              (rf_rt_addr),
		.rs_data              (rf_rs_data),
		.rt_data              (rf_rt_data),
		.id_alu_op            (id_alu_op),
		.id_alu_src           (id_alu_src),
		.id_imm               (id_imm),
		.id_reg1              (id_reg1),
		.id_reg2              (id_reg2),
		.id_wb_addr           (id_wb_addr),
		.id_branch_op         (id_branch_op),
		.id_branch_target     (id_branch_target),
		.id_branch_target_reg (id_branch_target_reg),
		.id_mem_op            (id_mem_op),
		.id_exc_code          (id_exc_code),
		.id_pc                (id_pc)
	);

	stage_ex u_ex (
		.clk                  (clk),
		.arst_n               (arst_n),
		.stall                (stall),
		.clear                (clear),
		.id_alu_op            (id_alu_op),
		.id_alu_src           (id_alu_src),
		.id_imm               (id_imm),
		.id_reg1              (id_reg1),
		.id_reg2              (id_reg2),
		.id_wb_addr           (id_wb_addr),
		.id_branch_op         (id_branch_op),
		.id_branch_target     (id_branch_target),
		.id_branch_target_reg (id_branch_target_reg),
		.id_mem_op            (id_mem_op),
		.id_exc_code          (id_exc_code),
		.id_pc                (id_pc),
		.branch_flag          (branch_flag),
		.branch_dest          (branch_dest),
		.mult_opr1            (mult_opr1),
		.mult_opr2            (mult_opr2),
		.ex_alu_result        (ex_alu_result),
		.ex_wb_addr           (ex_wb_addr),
		.ex_mem_op            (ex_mem_op),
		.ex_mem_data          (ex_mem_data),
		.ex_exc_code          (ex_exc_code),
		.ex_pc                (ex_pc)
	);

	stage_mem_wb u_mem_wb (
		.clk           (clk),
		.arst_n        (arst_n),
		.stall         (stall),
		.clear         (clear),
		.ex_alu_result (ex_alu_result),
		.ex_wb_addr    (ex_wb_addr),
		.ex_mem_op     (ex_mem_op),
		.ex_mem_data   (ex_mem_data),
		.ex_exc_code   (ex_exc_code),
		.ex_pc         (ex_pc),
		.wb_en         (wb_en),
		.wb_addr       (wb_addr),
		.wb_data       (wb_data),
		.exc_valid     (exc_valid),
		.exc_code      (exc_code),
		.exc_epc       (exc_epc),
		.exc_badvaddr  (exc_badvaddr)
	);

endmodule

// ==== dv/clk_rst_gen.sv ====
// free-running 40 ns clock; reset released on a falling edge after 10 cycles
`timescale 1ns/1ps

module clk_rst_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

// ==== dv/ex_pipe_tb.sv ====
// expected values come from a cycle model run over the table before it is applied
`timescale 1ns/1ps
`include "pipe_defines.svh"

module ex_pipe_tb;

	localparam int MAX_ROWS = 160;

	typedef struct packed {
		logic [4:0]  wd;
		logic [31:0] res;
		logic [1:0]  mem;
		logic [31:0] sdata;
		logic [2:0]  exc;
		logic [31:0] pc;
		logic        br;
		logic [31:0] bdest;
		logic        mult;
		logic [31:0] r1;
		logic [31:0] r2;
	} slot_t;

	logic clk;
	logic arst_n;
	logic stall;
	logic clear;
	pipe_pkg::alu_op_t alu_op;
	pipe_pkg::alu_src_t alu_src;
	logic [`PIPE_DATA_W-1:0] imm;
	logic [`PIPE_REG_ADDR_W-1:0] rs_addr;
	logic [`PIPE_REG_ADDR_W-1:0] rt_addr;
	logic [`PIPE_REG_ADDR_W-1:0] dec_wb_addr;
	pipe_pkg::branch_op_t branch_op;
	logic [`PIPE_DATA_W-1:0] branch_target;
	logic branch_target_reg;
	pipe_pkg::mem_op_t mem_op;
	pipe_pkg::exc_code_t exc_code_in;
	logic [`PIPE_DATA_W-1:0] pc;
	logic branch_flag;
	logic [`PIPE_DATA_W-1:0] branch_dest;
	logic [`PIPE_DATA_W-1:0] mult_opr1;
	logic [`PIPE_DATA_W-1:0] mult_opr2;
	logic wb_en;
	logic [`PIPE_REG_ADDR_W-1:0] wb_addr;
	logic [`PIPE_DATA_W-1:0] wb_data;
	logic exc_valid;
	pipe_pkg::exc_code_t exc_code;
	logic [`PIPE_DATA_W-1:0] exc_epc;
	logic [`PIPE_DATA_W-1:0] exc_badvaddr;

	// ==================================================
	// stimulus table and expected columns
	// ==================================================

	int n_rows;
	logic [3:0]  t_op    [MAX_ROWS];
	logic        t_src   [MAX_ROWS];
	logic [31:0] t_imm   [MAX_ROWS];
	logic [4:0]  t_rs    [MAX_ROWS];
	logic [4:0]  t_rt    [MAX_ROWS];
	logic [4:0]  t_wd    [MAX_ROWS];
	logic [1:0]  t_br    [MAX_ROWS];
	logic [31:0] t_btgt  [MAX_ROWS];
	logic        t_breg  [MAX_ROWS];
	logic [1:0]  t_mem   [MAX_ROWS];
	logic [2:0]  t_exc   [MAX_ROWS];
	logic        t_stall [MAX_ROWS];
	logic        t_clear [MAX_ROWS];
	logic        e_wb_en [MAX_ROWS];
	logic [4:0]  e_wb_addr [MAX_ROWS];
	logic [31:0] e_wb_data [MAX_ROWS];
	logic        e_exc_valid [MAX_ROWS];
	logic [2:0]  e_exc_code [MAX_ROWS];
	logic [31:0] e_epc   [MAX_ROWS];
	logic [31:0] e_badv  [MAX_ROWS];
	logic        e_br    [MAX_ROWS];
	logic [31:0] e_bdest [MAX_ROWS];
	logic        e_mok   [MAX_ROWS];
	logic [31:0] e_m1    [MAX_ROWS];
	logic [31:0] e_m2    [MAX_ROWS];

	logic [31:0] m_regs [32];
	logic [31:0] m_mem  [`PIPE_DMEM_DEPTH];

	clk_rst_gen u_clk_rst (
		.clk    (clk),
		.arst_n (arst_n)
	);

	ex_pipe_top UUT (
		.clk (clk), .arst_n (arst_n), .stall (stall), .clear (clear),
		.alu_op (alu_op), .alu_src (alu_src), .imm (imm),
		.rs_addr (rs_addr), .rt_addr (rt_addr), .dec_wb_addr (dec_wb_addr),
		.branch_op (branch_op), .branch_target (branch_target),
		.branch_target_reg (branch_target_reg), .mem_op (mem_op),
		.exc_code_in (exc_code_in), .pc (pc),
		.branch_flag (branch_flag), .branch_dest (branch_dest),
		.mult_opr1 (mult_opr1), .mult_opr2 (mult_opr2),
		.wb_en (wb_en), .wb_addr (wb_addr), .wb_data (wb_data),
		.exc_valid (exc_valid), .exc_code (exc_code),
		.exc_epc (exc_epc), .exc_badvaddr (exc_badvaddr)
	);

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else fail_now($sformatf("Mismatch %s: expected %h got %h", name, exp, got));
	endtask

	task automatic add_row(input logic [3:0] op, input logic src, input logic [31:0] imm_v,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] wd,
		input logic [1:0] br, input logic [31:0] btgt, input logic breg,
		input logic [1:0] mem, input logic [2:0] exc);
		t_op[n_rows] = op;
		t_src[n_rows] = src;
		t_imm[n_rows] = imm_v;
		t_rs[n_rows] = rs;
		t_rt[n_rows] = rt;
		t_wd[n_rows] = wd;
		t_br[n_rows] = br;
		t_btgt[n_rows] = btgt;
		t_breg[n_rows] = breg;
		t_mem[n_rows] = mem;
		t_exc[n_rows] = exc;
		t_stall[n_rows] = 1'b0;
		t_clear[n_rows] = 1'b0;
		n_rows++;
	endtask

	// nop row carrying the stall and clear levels
	task automatic add_ctrl(input logic st, input logic cl);
		add_row(4'd0, 1'b0, 32'h0, 5'd0, 5'd0, 5'd0, 2'd0, 32'h0, 1'b0, 2'd0, 3'd0);
		t_stall[n_rows-1] = st;
		t_clear[n_rows-1] = cl;
	endtask

	// ==================================================
	// reference model
	// ==================================================

	function automatic slot_t decode_row(input int k);
		slot_t s;
		logic [31:0] b;
		logic [31:0] opr2;
		logic illegal;
		s = '0;
		illegal = 1'b0;
		s.r1 = m_regs[t_rs[k]];
		s.r2 = m_regs[t_rt[k]];
		opr2 = t_src[k] ? t_imm[k] : s.r2;
		b = s.r1;
		case (t_op[k])
			4'd0: s.res = b + opr2;
			4'd1: s.res = b - opr2;
			4'd2: s.res = b & opr2;
			4'd3: s.res = b | opr2;
			4'd4: s.res = b ^ opr2;
			4'd5: s.res = {31'b0, $signed(b) < $signed(opr2)};
			4'd6: s.res = b << t_imm[k][4:0];
			4'd7: s.res = b >> t_imm[k][4:0];
			4'd8: s.res = t_imm[k] << 16;
			4'd9: s.res = 32'h0;
			default: begin
				s.res = 32'h0;
				illegal = 1'b1;
			end
		endcase
		s.exc = (t_exc[k] != 3'd0) ? t_exc[k] : (illegal ? 3'd2 : 3'd0);
		s.wd = (s.exc != 3'd0) ? 5'd0 : t_wd[k];
		s.mem = (s.exc != 3'd0) ? 2'd0 : t_mem[k];
		s.sdata = s.r2;
		s.pc = 32'h1000 + 32'(k) * 4;
		case (t_br[k])
			2'd1: s.br = (s.res == 32'h0);
			2'd2: s.br = (s.res != 32'h0);
			2'd3: s.br = 1'b1;
			default: s.br = 1'b0;
		endcase
		s.bdest = t_breg[k] ? s.r2 : t_btgt[k];
		s.mult = (t_op[k] == 4'd9) && (s.exc == 3'd0);
		return s;
	endfunction

	task automatic run_model();
		slot_t id_s;
		slot_t ex_s;
		slot_t nxt;
		logic [2:0] exc;
		logic adv;
		logic mis;
		logic mok;
		logic [31:0] m1;
		logic [31:0] m2;
		id_s = '0;
		ex_s = '0;
		mok = 1'b0;
		for (int i = 0; i < 32; i++) m_regs[i] = 32'h0;
		for (int k = 0; k < n_rows; k++) begin
			// operands are read before this edge's retire writes
			nxt = decode_row(k);
			adv = !t_stall[k] && !t_clear[k];
			mis = (ex_s.res[1:0] != 2'b00);
			exc = ex_s.exc;
			if (exc == 3'd0 && ex_s.mem == 2'd1 && mis) exc = 3'd3;
			if (exc == 3'd0 && ex_s.mem == 2'd2 && mis) exc = 3'd4;
			e_exc_valid[k] = adv && (exc != 3'd0);
			e_exc_code[k] = exc;
			e_epc[k] = ex_s.pc;
			e_badv[k] = ex_s.res;
			e_wb_en[k] = adv && ex_s.wd != 5'd0 && exc == 3'd0 && ex_s.mem != 2'd2;
			e_wb_addr[k] = ex_s.wd;
			e_wb_data[k] = (ex_s.mem == 2'd1) ? m_mem[ex_s.res[7:2]] : ex_s.res;
			if (adv && ex_s.mem == 2'd2 && !mis) m_mem[ex_s.res[7:2]] = ex_s.sdata;
			if (e_wb_en[k]) m_regs[ex_s.wd] = e_wb_data[k];
			if (adv && id_s.mult) begin
				mok = 1'b1;
				m1 = id_s.r1;
				m2 = id_s.r2;
			end
			e_mok[k] = mok;
			e_m1[k] = m1;
			e_m2[k] = m2;
			// branch of the slot in EX/MEM, out since the last falling edge
			e_br[k] = ex_s.br;
			e_bdest[k] = ex_s.bdest;
			if (t_clear[k]) begin
				ex_s = '0;
				id_s = '0;
			end else if (!t_stall[k]) begin
				ex_s = id_s;
				id_s = nxt;
			end
		end
	endtask

	task automatic drive_row(input int k);
		stall <= t_stall[k];
		clear <= t_clear[k];
		alu_op <= pipe_pkg::alu_op_t'(t_op[k]);
		alu_src <= pipe_pkg::alu_src_t'(t_src[k]);
		imm <= t_imm[k];
		rs_addr <= t_rs[k];
		rt_addr <= t_rt[k];
		dec_wb_addr <= t_wd[k];
		branch_op <= pipe_pkg::branch_op_t'(t_br[k]);
		branch_target <= t_btgt[k];
		branch_target_reg <= t_breg[k];
		mem_op <= pipe_pkg::mem_op_t'(t_mem[k]);
		exc_code_in <= pipe_pkg::exc_code_t'(t_exc[k]);
		pc <= 32'h1000 + 32'(k) * 4;
	endtask

	task automatic build_table();
		n_rows = 0;
		// random register loads, lui then or
		for (int r = 1; r <= 8; r++)
			add_row(4'd8, 1'b1, $urandom & 32'hffff, 5'd0, 5'd0, 5'(r), 2'd0, 0, 0, 2'd0, 3'd0);
		for (int r = 1; r <= 8; r++)
			add_row(4'd3, 1'b1, $urandom & 32'hffff, 5'(r), 5'd0, 5'(r), 2'd0, 0, 0, 2'd0, 3'd0);
		add_ctrl(0, 0);
		add_ctrl(0, 0);
		for (int op = 0; op < 9; op++) begin
			add_row(4'(op), 1'b0, $urandom, 5'(op % 8 + 1), 5'(8 - op % 8), 5'(9 + op),
				2'd0, 0, 0, 2'd0, 3'd0);
			add_row(4'(op), 1'b1, $urandom, 5'(op % 8 + 1), 5'd0, 5'(18 + op % 8),
				2'd0, 0, 0, 2'd0, 3'd0);
		end
		add_row(4'd0, 1'b0, 0, 5'd1, 5'd2, 5'd0, 2'd0, 0, 0, 2'd0, 3'd0);
		add_ctrl(0, 0);
		add_ctrl(0, 0);
		add_row(4'd0, 1'b0, 0, 5'd0, 5'd0, 5'd26, 2'd0, 0, 0, 2'd0, 3'd0);
		// branches
		add_row(4'd1, 1'b0, 0, 5'd1, 5'd1, 5'd0, 2'd1, 32'h400, 0, 2'd0, 3'd0);
		add_row(4'd1, 1'b0, 0, 5'd1, 5'd2, 5'd0, 2'd2, 32'h500, 0, 2'd0, 3'd0);
		add_row(4'd0, 1'b0, 0, 5'd0, 5'd3, 5'd0, 2'd3, 32'h0, 1, 2'd0, 3'd0);
		add_row(4'd0, 1'b1, 5, 5'd0, 5'd0, 5'd0, 2'd1, 32'h600, 0, 2'd0, 3'd0);
		// memory, aligned pair then misaligned pair
		add_row(4'd0, 1'b1, 32'h10, 5'd0, 5'd3, 5'd0, 2'd0, 0, 0, 2'd2, 3'd0);
		add_row(4'd0, 1'b1, 32'h10, 5'd0, 5'd0, 5'd27, 2'd0, 0, 0, 2'd1, 3'd0);
		add_row(4'd0, 1'b1, 32'h13, 5'd0, 5'd0, 5'd28, 2'd0, 0, 0, 2'd1, 3'd0);
		add_row(4'd0, 1'b1, 32'h22, 5'd0, 5'd4, 5'd0, 2'd0, 0, 0, 2'd2, 3'd0);
		// illegal opcode, then syscall over illegal
		add_row(4'd12, 1'b0, 0, 5'd1, 5'd2, 5'd29, 2'd0, 0, 0, 2'd0, 3'd0);
		add_row(4'd13, 1'b0, 0, 5'd1, 5'd2, 5'd30, 2'd0, 0, 0, 2'd0, 3'd1);
		add_row(4'd9, 1'b0, 0, 5'd3, 5'd4, 5'd0, 2'd0, 0, 0, 2'd0, 3'd0);
		add_row(4'd0, 1'b0, 0, 5'd5, 5'd6, 5'd31, 2'd0, 0, 0, 2'd0, 3'd0);
		// stall held three cycles behind two ops
		add_row(4'd4, 1'b0, 0, 5'd5, 5'd6, 5'd9, 2'd0, 0, 0, 2'd0, 3'd0);
		add_row(4'd9, 1'b0, 0, 5'd7, 5'd8, 5'd0, 2'd0, 0, 0, 2'd0, 3'd0);
		for (int i = 0; i < 3; i++) add_ctrl(1, 0);
		add_row(4'd1, 1'b0, 0, 5'd6, 5'd5, 5'd10, 2'd2, 32'h700, 0, 2'd0, 3'd0);
		// clear drops the two ops in flight
		add_row(4'd0, 1'b0, 0, 5'd1, 5'd2, 5'd11, 2'd0, 0, 0, 2'd0, 3'd0);
		add_row(4'd12, 1'b0, 0, 5'd1, 5'd2, 5'd12, 2'd3, 32'h800, 0, 2'd0, 3'd0);
		add_ctrl(0, 1);
		for (int i = 0; i < 4; i++) add_ctrl(0, 0);
	endtask

	initial begin
		int cnt;
		void'($urandom(90));
		build_table();
		run_model();
		stall = 1'b0;
		clear = 1'b0;
		alu_op = pipe_pkg::ALU_ADD;
		alu_src = pipe_pkg::SRC_REG;
		imm = '0;
		rs_addr = '0;
		rt_addr = '0;
		dec_wb_addr = '0;
		branch_op = pipe_pkg::BR_NONE;
		branch_target = '0;
		branch_target_reg = 1'b0;
		mem_op = pipe_pkg::MEM_NONE;
		exc_code_in = pipe_pkg::EXC_NONE;
		pc = '0;
		for (cnt = 0; cnt < 50 && arst_n !== 1'b1; cnt++) @(posedge clk);
		if (arst_n !== 1'b1) fail_now("reset was not released within 50 cycles");
		@(posedge clk);
		drive_row(0);
		for (int k = 0; k < n_rows; k++) begin
			@(posedge clk);
			if (k + 1 < n_rows) drive_row(k + 1);
			#5;
			check_val("wb_en", wb_en, e_wb_en[k]);
			if (e_wb_en[k]) begin
				check_val("wb_addr", wb_addr, e_wb_addr[k]);
				check_val("wb_data", wb_data, e_wb_data[k]);
			end
			check_val("exc_valid", exc_valid, e_exc_valid[k]);
			if (e_exc_valid[k]) begin
				check_val("exc_code", exc_code, e_exc_code[k]);
				check_val("exc_epc", exc_epc, e_epc[k]);
				if (e_exc_code[k] >= 3'd3) check_val("exc_badvaddr", exc_badvaddr, e_badv[k]);
			end
			if (e_mok[k]) begin
				check_val("mult_opr1", mult_opr1, e_m1[k]);
				check_val("mult_opr2", mult_opr2, e_m2[k]);
			end
			// same slot as the write-back outputs
			check_val("branch_flag", branch_flag, e_br[k]);
			if (e_br[k]) check_val("branch_dest", branch_dest, e_bdest[k]);
		end
		$display("sim passed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+source
source/pipe_pkg.sv
source/reg_file.sv
source/stage_issue.sv
source/alu.sv
source/stage_ex.sv
source/stage_mem_wb.sv
source/ex_pipe_top.sv
dv/clk_rst_gen.sv
dv/ex_pipe_tb.sv
